// File: Makefile
VERILATOR ?= verilator
TOP       ?= gps_channel_tb
FILELIST  ?= gps_channel.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= *** PASSED ***
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF '$(PASS_STR)' $(LOG); then \
	   echo "Simulation passed."; \
	else \
	   echo "Simulation failed, see $(LOG)."; \
	   exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: gps_channel.f
src/gps_pkg.sv
src/carrier_mixer.sv
src/code_generator.sv
src/correlator_bank.sv
src/gps_channel.sv
verif/gps_channel_assert.sv
verif/gps_channel_tb.sv

// File: src/carrier_mixer.sv
`timescale 1ns/1ps

module carrier_mixer import gps_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    data_valid_i,
   input  sample_t                 data_i,
   input  logic [CARR_PHASE_W-1:0] carr_inc_i,
   output logic                    wiped_valid_o,
   output wiped_t                  wiped_i_o,
   output wiped_t                  wiped_q_o
);

   // Lookup index is the top bits of the phase.
   localparam int IDX_W = 3;

   logic [CARR_PHASE_W-1:0] carr_phase;
   logic [IDX_W-1:0]        carr_idx;
   logic                    carr_off;
   quadrant_e               cos_quad;
   quadrant_e               sin_quad;
   carr_amp_t               cos_amp;
   carr_amp_t               sin_amp;

   ////////////////////////////////////////////////////////////////////////////
   // Carrier NCO
   ////////////////////////////////////////////////////////////////////////////

   // Phase steps once per accepted sample.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         carr_phase <= '0;
      end else if (data_valid_i) begin
         carr_phase <= carr_phase + carr_inc_i;
      end
   end

   // The current sample is mixed with the phase before the add.
   assign carr_idx = carr_phase[CARR_PHASE_W-1 -: IDX_W];
   assign cos_quad = quadrant_e'(carr_idx[IDX_W-1 -: 2]);
   assign carr_off = carr_idx[0];

   ////////////////////////////////////////////////////////////////////////////
   // Cosine and sine lookup
   ////////////////////////////////////////////////////////////////////////////

   // Sine lags cosine by one quadrant.
   always_comb begin
      case (cos_quad)
         Q0:      sin_quad = Q3;
         Q1:      sin_quad = Q0;
         Q2:      sin_quad = Q1;
         default: sin_quad = Q2;
      endcase
   end

   assign cos_amp = CARR_COS_TBL[{cos_quad, carr_off}];
   assign sin_amp = CARR_COS_TBL[{sin_quad, carr_off}];

   ////////////////////////////////////////////////////////////////////////////
   // Carrier wipe-off
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wiped_valid_o <= 1'b0;
      end else begin
         wiped_valid_o <= data_valid_i;
      end
   end

   always_ff @(posedge clk) begin
      if (data_valid_i) begin
         wiped_i_o <= wiped_t'(data_i) * wiped_t'(cos_amp);
         wiped_q_o <= wiped_t'(data_i) * wiped_t'(sin_amp);
      end
   end

endmodule

// File: src/code_generator.sv
`timescale 1ns/1ps

module code_generator import gps_pkg::*; (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    data_valid_i,
   input  logic [CODE_PHASE_W-1:0] code_inc_i,
   input  prn_t                    prn_i,
   output logic                    chip_early_o,
   output logic                    chip_prompt_o,
   output logic                    chip_late_o
);

   // G2 phase selector taps per PRN, one hex digit per tap.
   localparam logic [7:0] G2_TAPS [32] = '{
      8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2a, 8'h18, 8'h29,
      8'h3a, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9a,
      8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
      8'h57, 8'h68, 8'h79, 8'h8a, 8'h16, 8'h27, 8'h38, 8'h49
   };

   logic [CODE_PHASE_W-1:0] code_phase;
   logic [CODE_PHASE_W:0]   phase_sum;
   logic                    half_carry;
   logic                    second_half;
   logic [10:1]             g1;
   logic [10:1]             g2;
   logic [3:0]              tap_a;
   logic [3:0]              tap_b;
   logic                    ca_bit;
   logic [2:0]              chip_hist;

   ////////////////////////////////////////////////////////////////////////////
   // Code NCO
   ////////////////////////////////////////////////////////////////////////////

   assign phase_sum  = {1'b0, code_phase} + {1'b0, code_inc_i};
   // Each carry out is half a chip.
   assign half_carry = data_valid_i & phase_sum[CODE_PHASE_W];

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         code_phase  <= '0;
         second_half <= 1'b0;
      end else if (data_valid_i) begin
         code_phase <= phase_sum[CODE_PHASE_W-1:0];
         if (half_carry) begin
            second_half <= ~second_half;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // C/A Gold code
   ////////////////////////////////////////////////////////////////////////////

   assign tap_a  = G2_TAPS[prn_i][7:4];
   assign tap_b  = G2_TAPS[prn_i][3:0];
   assign ca_bit = g1[10] ^ g2[tap_a] ^ g2[tap_b];

   // Both registers step at the end of a full chip.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         g1 <= '1;
         g2 <= '1;
      end else if (half_carry && second_half) begin
         g1 <= {g1[9:1], g1[3] ^ g1[10]};
         g2 <= {g2[9:1], g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10]};
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Early, prompt and late chips
   ////////////////////////////////////////////////////////////////////////////

   // Bit 0 is the newest half-chip, which is early.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         chip_hist <= '1;
      end else if (half_carry) begin
         chip_hist <= {chip_hist[1:0], ca_bit};
      end
   end

   // Registered with the carrier result for the same sample.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         chip_early_o  <= 1'b1;
         chip_prompt_o <= 1'b1;
         chip_late_o   <= 1'b1;
      end else if (data_valid_i) begin
         chip_early_o  <= chip_hist[0];
         chip_prompt_o <= chip_hist[1];
         chip_late_o   <= chip_hist[2];
      end
   end

endmodule

// File: src/correlator_bank.sv
`timescale 1ns/1ps

module correlator_bank import gps_pkg::*; #(
   parameter int ACC_LEN = 16
) (
   input  logic   clk,
   input  logic   rst_n_i,
   input  logic   wiped_valid_i,
   input  wiped_t wiped_i_i,
   input  wiped_t wiped_q_i,
   input  logic   chip_early_i,
   input  logic   chip_prompt_i,
   input  logic   chip_late_i,
   output logic   acc_valid_o,
   output acc_t   i_early_o,
   output acc_t   q_early_o,
   output acc_t   i_prompt_o,
   output acc_t   q_prompt_o,
   output acc_t   i_late_o,
   output acc_t   q_late_o
);

   localparam int CNT_W    = $clog2(ACC_LEN);
   localparam int NUM_TAPS = 3;

   logic [CNT_W-1:0]    smp_cnt;
   logic                first_smp;
   logic                last_smp;
   logic                dump;
   logic [NUM_TAPS-1:0] chips;
   acc_t                sum_i [NUM_TAPS];
   acc_t                sum_q [NUM_TAPS];

   // Chip of 1 keeps the sign, chip of 0 flips it.
   function automatic acc_t code_wipe(input wiped_t val, input logic chip);
      acc_t ext;
      ext = acc_t'(val);
      return chip ? ext : -ext;
   endfunction

   // Index 0 is early, 2 is late.
   assign chips = {chip_late_i, chip_prompt_i, chip_early_i};

   ////////////////////////////////////////////////////////////////////////////
   // Sample counter
   ////////////////////////////////////////////////////////////////////////////

   assign first_smp = (smp_cnt == '0);
   assign last_smp  = (smp_cnt == CNT_W'(ACC_LEN - 1));

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         smp_cnt <= '0;
         dump    <= 1'b0;
      end else begin
         dump <= wiped_valid_i & last_smp;
         if (wiped_valid_i) begin
            smp_cnt <= last_smp ? '0 : smp_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Code wipe-off and integrate
   ////////////////////////////////////////////////////////////////////////////

   // First sample of an accumulation starts a fresh sum.
   always_ff @(posedge clk) begin
      if (wiped_valid_i) begin
         for (int k = 0; k < NUM_TAPS; k++) begin
            sum_i[k] <= (first_smp ? '0 : sum_i[k]) + code_wipe(wiped_i_i, chips[k]);
            sum_q[k] <= (first_smp ? '0 : sum_q[k]) + code_wipe(wiped_q_i, chips[k]);
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Dump
   ////////////////////////////////////////////////////////////////////////////

   // Outputs hold until the next dump.
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         acc_valid_o <= 1'b0;
         i_early_o   <= '0;
         q_early_o   <= '0;
         i_prompt_o  <= '0;
         q_prompt_o  <= '0;
         i_late_o    <= '0;
         q_late_o    <= '0;
      end else begin
         acc_valid_o <= dump;
         if (dump) begin
            i_early_o  <= sum_i[0];
            q_early_o  <= sum_q[0];
            i_prompt_o <= sum_i[1];
            q_prompt_o <= sum_q[1];
            i_late_o   <= sum_i[2];
            q_late_o   <= sum_q[2];
         end
      end
   end

endmodule

// File: src/gps_channel.sv
`timescale 1ns/1ps

module gps_channel import gps_pkg::*; #(
   parameter int ACC_LEN = 16
) (
   input  logic                    clk,
   input  logic                    rst_n_i,
   input  logic                    data_valid_i,
   input  sample_t                 data_i,
   input  logic [CARR_PHASE_W-1:0] carr_inc_i,
   input  logic [CODE_PHASE_W-1:0] code_inc_i,
   input  prn_t                    prn_i,
   output logic                    acc_valid_o,
   output acc_t                    i_early_o,
   output acc_t                    q_early_o,
   output acc_t                    i_prompt_o,
   output acc_t                    q_prompt_o,
   output acc_t                    i_late_o,
   output acc_t                    q_late_o
);

   // Carrier path results.
   logic   wiped_valid;
   wiped_t wiped_i;
   wiped_t wiped_q;

   // Code path results, aligned with the carrier path.
   logic chip_early;
   logic chip_prompt;
   logic chip_late;

   carrier_mixer u_carrier_mixer (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .data_valid_i  (data_valid_i),
      .data_i        (data_i),
      .carr_inc_i    (carr_inc_i),
      .wiped_valid_o (wiped_valid),
      .wiped_i_o     (wiped_i),
      .wiped_q_o     (wiped_q)
   );

   code_generator u_code_generator (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .data_valid_i  (data_valid_i),
      .code_inc_i    (code_inc_i),
      .prn_i         (prn_i),
      .chip_early_o  (chip_early),
      .chip_prompt_o (chip_prompt),
      .chip_late_o   (chip_late)
   );

   correlator_bank #(
      .ACC_LEN (ACC_LEN)
   ) u_correlator_bank (
      .clk           (clk),
      .rst_n_i       (rst_n_i),
      .wiped_valid_i (wiped_valid),
      .wiped_i_i     (wiped_i),
      .wiped_q_i     (wiped_q),
      .chip_early_i  (chip_early),
      .chip_prompt_i (chip_prompt),
      .chip_late_i   (chip_late),
      .acc_valid_o   (acc_valid_o),
      .i_early_o     (i_early_o),
      .q_early_o     (q_early_o),
      .i_prompt_o    (i_prompt_o),
      .q_prompt_o    (q_prompt_o),
      .i_late_o      (i_late_o),
      .q_late_o      (q_late_o)
   );

endmodule

// File: src/gps_pkg.sv
package gps_pkg;

   // Baseband input samples.
   localparam int SAMPLE_W = 4;
   typedef logic signed [SAMPLE_W-1:0] sample_t;

   // NCO accumulator widths.
   localparam int CARR_PHASE_W = 16;
   localparam int CODE_PHASE_W = 16;

   // Carrier amplitude.
   localparam int CARR_AMP_W = 3;
   typedef logic signed [CARR_AMP_W-1:0] carr_amp_t;
   localparam int CARR_AMP = 2;

   // Sample after carrier wipe-off.
   typedef logic signed [SAMPLE_W+CARR_AMP_W-1:0] wiped_t;

   // Integrate-and-dump sums.
   localparam int ACC_W = 20;
   typedef logic signed [ACC_W-1:0] acc_t;

   // PRN number minus one.
   typedef logic [4:0] prn_t;

   // Carrier quadrant, the top two bits of the lookup index.
   typedef enum logic [1:0] {
      Q0,
      Q1,
      Q2,
      Q3
   } quadrant_e;

   // Cosine over one carrier period, indexed by {quadrant, offset}.
   // Sine reads the same table one quadrant back.
   localparam carr_amp_t CARR_COS_TBL [8] = '{
      carr_amp_t'(CARR_AMP),
      carr_amp_t'(CARR_AMP / 2),
      carr_amp_t'(0),
      carr_amp_t'(-CARR_AMP / 2),
      carr_amp_t'(-CARR_AMP),
      carr_amp_t'(-CARR_AMP / 2),
      carr_amp_t'(0),
      carr_amp_t'(CARR_AMP / 2)
   };

endpackage

// File: verif/gps_channel_assert.sv
`timescale 1ns/1ps

module gps_channel_assert import gps_pkg::*; #(
   parameter int ACC_LEN = 16
) (
   input logic clk,
   input logic rst_n_i,
   input logic data_valid_i,
   input logic acc_valid_i,
   input acc_t i_early_i,
   input acc_t q_early_i,
   input acc_t i_prompt_i,
   input acc_t q_prompt_i,
   input acc_t i_late_i,
   input acc_t q_late_i
);

   // Number of failed assertions, read by the testbench.
   int   err_cnt = 0;
   int   smp_cnt;
   logic last_in;
   logic seen_dump;
   logic sums_zero;

   ////////////////////////////////////////////////////////////////////////////
   // Reference sample count
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         smp_cnt   <= 0;
         seen_dump <= 1'b0;
      end else begin
         if (data_valid_i) begin
            smp_cnt <= (smp_cnt == ACC_LEN - 1) ? 0 : smp_cnt + 1;
         end
         if (acc_valid_i) begin
            seen_dump <= 1'b1;
         end
      end
   end

   // Last accepted sample of an accumulation.
   assign last_in   = rst_n_i & data_valid_i & (smp_cnt == ACC_LEN - 1);
   assign sums_zero = (i_early_i == '0) && (q_early_i == '0) && (i_prompt_i == '0) &&
                      (q_prompt_i == '0) && (i_late_i == '0) && (q_late_i == '0);

   ////////////////////////////////////////////////////////////////////////////
   // Port assertions
   ////////////////////////////////////////////////////////////////////////////

   a_dump_after_last: assert property (@(posedge clk) disable iff (!rst_n_i)
      $past(last_in, 3) |-> acc_valid_i)
      else begin
         err_cnt++;
         $error("acc_valid_o missing three cycles after the last sample");
      end

   a_dump_only_after_last: assert property (@(posedge clk) disable iff (!rst_n_i)
      acc_valid_i |-> $past(last_in, 3))
      else begin
         err_cnt++;
         $error("acc_valid_o high without a completed accumulation");
      end

   // One-cycle pulse.
   a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      $past(acc_valid_i) |-> !acc_valid_i)
      else begin
         err_cnt++;
         $error("acc_valid_o high for two cycles in a row");
      end

   a_idle_sums: assert property (@(posedge clk) disable iff (!rst_n_i)
      (!seen_dump && !acc_valid_i) |-> sums_zero)
      else begin
         err_cnt++;
         $error("Sums not zero before the first dump");
      end

endmodule

// File: verif/gps_channel_tb.sv
`timescale 1ns/1ps

module gps_channel_tb import gps_pkg::*; ();

   localparam int ACC_LEN = 16;
   localparam int TIMEOUT = 200;

   logic                    clk;
   logic                    rst_n;
   logic                    data_valid;
   sample_t                 data;
   logic [CARR_PHASE_W-1:0] carr_inc;
   logic [CODE_PHASE_W-1:0] code_inc;
   prn_t                    prn;
   logic                    acc_valid;
   acc_t                    i_early;
   acc_t                    q_early;
   acc_t                    i_prompt;
   acc_t                    q_prompt;
   acc_t                    i_late;
   acc_t                    q_late;
   integer                  seed;

   gps_channel #(
      .ACC_LEN (ACC_LEN)
   ) dut (
      .clk          (clk),
      .rst_n_i      (rst_n),
      .data_valid_i (data_valid),
      .data_i       (data),
      .carr_inc_i   (carr_inc),
      .code_inc_i   (code_inc),
      .prn_i        (prn),
      .acc_valid_o  (acc_valid),
      .i_early_o    (i_early),
      .q_early_o    (q_early),
      .i_prompt_o   (i_prompt),
      .q_prompt_o   (q_prompt),
      .i_late_o     (i_late),
      .q_late_o     (q_late)
   );

   bind gps_channel gps_channel_assert #(
      .ACC_LEN (ACC_LEN)
   ) u_check (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .data_valid_i (data_valid_i),
      .acc_valid_i  (acc_valid_o),
      .i_early_i    (i_early_o),
      .q_early_i    (q_early_o),
      .i_prompt_i   (i_prompt_o),
      .q_prompt_i   (q_prompt_o),
      .i_late_i     (i_late_o),
      .q_late_i     (q_late_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic fail_run();
      $display("*** FAILED ***");
      $fatal(1, "Simulation stopped at the first error.");
   endtask

   task automatic apply_reset();
      rst_n = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   // One accumulation worth of samples; the last one has no gap after it.
   task automatic send_accum(input logic rand_smp, input sample_t d, input logic gaps,
                             output int max_abs);
      sample_t smp;
      int      gap;
      int      mag;
      max_abs = 0;
      for (int n = 0; n < ACC_LEN; n++) begin
         smp = rand_smp ? sample_t'($random(seed)) : d;
         gap = (gaps && n != ACC_LEN - 1) ? ($random(seed) & 3) : 0;
         mag = (smp < 0) ? -int'(smp) : int'(smp);
         if (mag > max_abs) begin
            max_abs = mag;
         end
         data_valid = 1'b1;
         data       = smp;
         @(posedge clk);
         #1;
         data_valid = 1'b0;
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
   endtask

   task automatic wait_dump(input string phase);
      int cycles;
      cycles = 0;
      while (!acc_valid && cycles < TIMEOUT) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      if (!acc_valid) begin
         $display("Timed out after %0d cycles waiting for acc_valid_o in the %s phase.",
                  TIMEOUT, phase);
         fail_run();
      end
   endtask

   task automatic check_sum(input string name, input acc_t got, input int exp);
      assert (int'(got) == exp) else begin
         $display("** Error at %0t ns: %s is %0d, expected %0d.", $time, name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_all(input int i_exp, input int q_exp);
      check_sum("i_early", i_early, i_exp);
      check_sum("q_early", q_early, q_exp);
      check_sum("i_prompt", i_prompt, i_exp);
      check_sum("q_prompt", q_prompt, q_exp);
      check_sum("i_late", i_late, i_exp);
      check_sum("q_late", q_late, q_exp);
   endtask

   task automatic check_bound(input string name, input acc_t got, input int bound);
      int mag;
      mag = (got < 0) ? -int'(got) : int'(got);
      assert (mag <= bound) else begin
         $display("** Error at %0t ns: %s is %0d, magnitude above %0d.",
                  $time, name, got, bound);
         fail_run();
      end
   endtask

   // Concurrent assertion failures are counted in the bound checker.
   always @(negedge clk) begin
      if (dut.u_check.err_cnt != 0) begin
         $display("A port assertion failed, see the message above.");
         fail_run();
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int max_abs;
      int bound;
      seed       = 32'h3697cd39;
      rst_n      = 1'b0;
      data_valid = 1'b0;
      data       = '0;
      carr_inc   = '0;
      code_inc   = '0;
      prn        = '0;
      apply_reset();

      // No carrier and no code motion, so every chip stays at 1.
      prn = prn_t'($random(seed));
      send_accum(1'b0, 4'sd3, 1'b0, max_abs);
      wait_dump("constant sample, back to back");
      check_all(ACC_LEN * 3 * CARR_AMP, 0);
      send_accum(1'b0, -4'sd5, 1'b1, max_abs);
      wait_dump("constant sample, random gaps");
      check_all(ACC_LEN * -5 * CARR_AMP, 0);

      // One lookup index per sample gives two whole carrier periods.
      apply_reset();
      carr_inc = 16'h2000;
      send_accum(1'b0, 4'sd7, 1'b1, max_abs);
      wait_dump("full carrier periods");
      check_all(0, 0);
      send_accum(1'b0, -4'sd8, 1'b0, max_abs);
      wait_dump("full carrier periods, back to back");
      check_all(0, 0);

      // Moving code on a fixed carrier at cosine peak.
      apply_reset();
      carr_inc = '0;
      code_inc = 16'($random(seed)) | 16'h2000;
      prn      = prn_t'($random(seed));
      repeat (4) begin
         send_accum(1'b1, '0, 1'b1, max_abs);
         wait_dump("random code");
         bound = ACC_LEN * max_abs * CARR_AMP;
         check_sum("q_early", q_early, 0);
         check_sum("q_prompt", q_prompt, 0);
         check_sum("q_late", q_late, 0);
         check_bound("i_early", i_early, bound);
         check_bound("i_prompt", i_prompt, bound);
         check_bound("i_late", i_late, bound);
      end

      repeat (4) @(posedge clk);
      #1;
      if (dut.u_check.err_cnt != 0) begin
         $display("A port assertion failed during the run.");
         fail_run();
      end else begin
         $display("*** PASSED ***");
         $finish;
      end
   end

endmodule
